/* Makefile */
VERILATOR ?= verilator
TOP       ?= self_attn_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
design/attn_pkg.sv
design/matrix_store.sv
design/attn_seq.sv
design/proj_unit.sv
design/score_unit.sv
design/attn_out.sv
design/self_attn_top.sv
tb/tb_clock_gen.sv
tb/self_attn_checker.sv
tb/self_attn_tb.sv

/* design/attn_out.sv */
// output stage: one S.V entry per cycle in row-major order
// out_data_o is forced to zero whenever out_valid_o is low
`timescale 1ns/1ps

module attn_out (
  input  logic             G_clock_K_reg,
  input  logic             rst_n,
  input  attn_pkg::phase_t phase_i,
  input  attn_pkg::idx_t   row_idx_i,
  input  attn_pkg::idx_t   col_idx_i,
  input  attn_pkg::score_t s_i [attn_pkg::DIM][attn_pkg::DIM],
  input  attn_pkg::proj_t  v_i [attn_pkg::DIM][attn_pkg::DIM],
  output logic             out_valid_o,
  output attn_pkg::out_t   out_data_o
);
  import attn_pkg::*;

  out_t acc;

  // S row i against V column j
  always_comb begin
    acc = '0;
    for (int k = 0; k < DIM; k++) begin
      acc = acc + out_t'(s_i[row_idx_i][k]) * out_t'(v_i[k][col_idx_i]);
    end
  end

  always_ff @(posedge G_clock_K_reg or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
      out_data_o  <= '0;
    end else if (phase_i == PH_OUT) begin
      out_valid_o <= 1'b1;
      out_data_o  <= acc;
    end else begin
      // idle output is all zeros
      out_valid_o <= 1'b0;
      out_data_o  <= '0;
    end
  end

endmodule

/* design/attn_pkg.sv */
// shared dimensions, element types and phase codes for the attention engine
// imported by every design file; ports refer to these by scoped name
package attn_pkg;

  // matrix is always 8x8, rows beyond T stay zero
  localparam int DIM = 8;

  localparam int DATA_W  = 8;
  localparam int PROJ_W  = 20;
  localparam int SCORE_W = 40;
  localparam int OUT_W   = 64;

  // cycles per streamed matrix and per scoring pass
  localparam int LOAD_CYCLES  = 64;
  localparam int SCORE_CYCLES = 64;

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [PROJ_W-1:0]  proj_t;
  typedef logic signed [SCORE_W-1:0] score_t;
  typedef logic signed [OUT_W-1:0]   out_t;
  typedef logic [2:0]                idx_t;
  typedef logic [3:0]                t_t;

  typedef enum logic [2:0] {PH_IDLE, PH_LOAD_X, PH_LOAD_K, PH_LOAD_V, PH_SCORE, PH_OUT} phase_t;

endpackage

/* design/attn_seq.sv */
// run sequencer: latches T, counts steps and walks the phases of one run
// index and write strobes are combinational, the store writes on the next edge
`timescale 1ns/1ps

module attn_seq (
  input  logic             G_clock_K_reg,
  input  logic             rst_n,
  input  logic             in_valid_i,
  input  attn_pkg::t_t     t_i,
  output attn_pkg::phase_t phase_o,
  output attn_pkg::idx_t   row_idx_o,
  output attn_pkg::idx_t   col_idx_o,
  output logic             x_we_o,
  output logic             w_we_o,
  output logic             clr_o
);
  import attn_pkg::*;

  phase_t     phase_q;
  logic [5:0] step_q;
  idx_t       last_row_q;
  idx_t       last_row;
  logic       start;
  logic       loading;

  // T of 1 or 4 is taken as is, anything else means 8 rows
  function automatic idx_t last_row_of(t_t t);
    case (t)
      4'd1:    return 3'd0;
      4'd4:    return 3'd3;
      default: return 3'd7;
    endcase
  endfunction

  always_comb begin
    start   = (phase_q == PH_IDLE) && in_valid_i;
    loading = (phase_q == PH_IDLE) || (phase_q == PH_LOAD_X);
    // first cycle of a run still sees T on the pins
    last_row = (phase_q == PH_IDLE) ? last_row_of(t_i) : last_row_q;
  end

  // step counter is row-major, row in the top three bits
  assign row_idx_o = step_q[5:3];
  assign col_idx_o = step_q[2:0];
  assign phase_o   = phase_q;
  assign clr_o     = start;
  assign w_we_o    = in_valid_i && loading;
  // masked rows never reach the X store
  assign x_we_o    = in_valid_i && loading && (step_q[5:3] <= last_row);

  always_ff @(posedge G_clock_K_reg or negedge rst_n) begin
    if (!rst_n) begin
      phase_q    <= PH_IDLE;
      step_q     <= '0;
      last_row_q <= '0;
    end else if (start) begin
      // entry 0 is written this cycle, so step 1 follows
      phase_q    <= PH_LOAD_X;
      step_q     <= 6'd1;
      last_row_q <= last_row;
    end else begin
      case (phase_q)
        PH_LOAD_X, PH_LOAD_K, PH_LOAD_V: begin
          step_q <= step_q + 6'd1;
          if (step_q == 6'(LOAD_CYCLES - 1)) begin
            phase_q <= (phase_q == PH_LOAD_X) ? PH_LOAD_K :
                       (phase_q == PH_LOAD_K) ? PH_LOAD_V : PH_SCORE;
          end
        end
        PH_SCORE: begin
          step_q <= step_q + 6'd1;
          if (step_q == 6'(SCORE_CYCLES - 1)) phase_q <= PH_OUT;
        end
        PH_OUT: begin
          // stop after the last column of the last live row
          if (step_q == {last_row_q, 3'b111}) begin
            phase_q <= PH_IDLE;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 6'd1;
          end
        end
        default: begin
          phase_q <= PH_IDLE;
          step_q  <= '0;
        end
      endcase
    end
  end

endmodule

/* design/matrix_store.sv */
// 8x8 register matrix with one addressed write per cycle
// the whole matrix is visible at once for parallel reads
`timescale 1ns/1ps

module matrix_store #(
  parameter type elem_t = attn_pkg::data_t
) (
  input  logic           G_clock_K_reg,
  input  logic           rst_n,
  input  logic           clr_i,
  input  logic           we_i,
  input  attn_pkg::idx_t row_i,
  input  attn_pkg::idx_t col_i,
  input  elem_t          data_i,
  output elem_t          mat_o [attn_pkg::DIM][attn_pkg::DIM]
);
  import attn_pkg::*;

  always_ff @(posedge G_clock_K_reg or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < DIM; r++) begin
        for (int c = 0; c < DIM; c++) begin
          mat_o[r][c] <= '0;
        end
      end
    end else begin
      // clear first, a write in the same cycle still lands
      if (clr_i) begin
        for (int r = 0; r < DIM; r++) begin
          for (int c = 0; c < DIM; c++) begin
            mat_o[r][c] <= '0;
          end
        end
      end
      if (we_i) mat_o[row_i][col_i] <= data_i;
    end
  end

endmodule

/* design/proj_unit.sv */
// Q, K and V accumulators
// Q uses the stored Wq and K the streamed Wk during the K load,
// V is built from the streamed Wv during the V load
`timescale 1ns/1ps

module proj_unit (
  input  logic             G_clock_K_reg,
  input  logic             rst_n,
  input  logic             clr_i,
  input  attn_pkg::phase_t phase_i,
  input  attn_pkg::idx_t   row_idx_i,
  input  attn_pkg::idx_t   col_idx_i,
  input  attn_pkg::data_t  x_i   [attn_pkg::DIM][attn_pkg::DIM],
  input  attn_pkg::data_t  wq_i  [attn_pkg::DIM][attn_pkg::DIM],
  input  attn_pkg::data_t  w_k_i,
  input  attn_pkg::data_t  w_v_i,
  output attn_pkg::proj_t  q_o   [attn_pkg::DIM][attn_pkg::DIM],
  output attn_pkg::proj_t  k_o   [attn_pkg::DIM][attn_pkg::DIM],
  output attn_pkg::proj_t  v_o   [attn_pkg::DIM][attn_pkg::DIM]
);
  import attn_pkg::*;

  always_ff @(posedge G_clock_K_reg or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
          q_o[i][j] <= '0;
          k_o[i][j] <= '0;
          v_o[i][j] <= '0;
        end
      end
    end else if (clr_i) begin
      // new run starts from empty sums
      for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
          q_o[i][j] <= '0;
          k_o[i][j] <= '0;
          v_o[i][j] <= '0;
        end
      end
    end else if (phase_i == PH_LOAD_K) begin
      // weight (r, c) touches column c of every row
      for (int i = 0; i < DIM; i++) begin
        q_o[i][col_idx_i] <= q_o[i][col_idx_i]
                             + proj_t'(x_i[i][row_idx_i]) * proj_t'(wq_i[row_idx_i][col_idx_i]);
        k_o[i][col_idx_i] <= k_o[i][col_idx_i]
                             + proj_t'(x_i[i][row_idx_i]) * proj_t'(w_k_i);
      end
    end else if (phase_i == PH_LOAD_V) begin
      // masked rows have zero X so their sums stay zero
      for (int i = 0; i < DIM; i++) begin
        v_o[i][col_idx_i] <= v_o[i][col_idx_i]
                             + proj_t'(x_i[i][row_idx_i]) * proj_t'(w_v_i);
      end
    end
  end

endmodule

/* design/score_unit.sv */
// score matrix S, one entry per cycle during the scoring phase
// entry (i, j) is relu(Q row i . K row j) / 3, truncated
`timescale 1ns/1ps

module score_unit (
  input  logic             G_clock_K_reg,
  input  logic             rst_n,
  input  logic             clr_i,
  input  attn_pkg::phase_t phase_i,
  input  attn_pkg::idx_t   row_idx_i,
  input  attn_pkg::idx_t   col_idx_i,
  input  attn_pkg::proj_t  q_i [attn_pkg::DIM][attn_pkg::DIM],
  input  attn_pkg::proj_t  k_i [attn_pkg::DIM][attn_pkg::DIM],
  output attn_pkg::score_t s_o [attn_pkg::DIM][attn_pkg::DIM]
);
  import attn_pkg::*;

  score_t dot;
  score_t score;

  always_comb begin
    dot = '0;
    // 8 products, 40 bits leave headroom over the 37-bit worst case
    for (int k = 0; k < DIM; k++) begin
      dot = dot + score_t'(q_i[row_idx_i][k]) * score_t'(k_i[col_idx_i][k]);
    end
    // negatives to zero, then divide
    score = (dot < 0) ? '0 : dot / 3;
  end

  matrix_store #(
    .elem_t (score_t)
  ) s_store_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .clr_i         (clr_i),
    .we_i          (phase_i == PH_SCORE),
    .row_i         (row_idx_i),
    .col_i         (col_idx_i),
    .data_i        (score),
    .mat_o         (s_o)
  );

endmodule

/* design/self_attn_top.sv */
// single-head self-attention engine, top level
// streams X and Wq, then Wk, then Wv; T x 8 results follow the scoring pass
`timescale 1ns/1ps

module self_attn_top (
  input  logic            G_clock_K_reg,
  input  logic            rst_n,
  input  logic            in_valid_i,
  input  attn_pkg::t_t    T_i,
  input  attn_pkg::data_t in_data_i,
  input  attn_pkg::data_t w_q_i,
  input  attn_pkg::data_t w_k_i,
  input  attn_pkg::data_t w_v_i,
  output logic            out_valid_o,
  output attn_pkg::out_t  out_data_o
);
  import attn_pkg::*;

  phase_t phase;
  idx_t   row_idx;
  idx_t   col_idx;
  logic   x_we;
  logic   w_we;
  logic   clr;
  data_t  x_mat  [DIM][DIM];
  data_t  wq_mat [DIM][DIM];
  proj_t  q_mat  [DIM][DIM];
  proj_t  k_mat  [DIM][DIM];
  proj_t  v_mat  [DIM][DIM];
  score_t s_mat  [DIM][DIM];

  attn_seq seq_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .t_i           (T_i),
    .phase_o       (phase),
    .row_idx_o     (row_idx),
    .col_idx_o     (col_idx),
    .x_we_o        (x_we),
    .w_we_o        (w_we),
    .clr_o         (clr)
  );

  // input matrix, masked rows stay zero
  matrix_store #(.elem_t(data_t)) x_store_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .clr_i         (clr),
    .we_i          (x_we),
    .row_i         (row_idx),
    .col_i         (col_idx),
    .data_i        (in_data_i),
    .mat_o         (x_mat)
  );

  // Wq is kept whole, Q is built during the K load
  matrix_store #(.elem_t(data_t)) wq_store_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .clr_i         (clr),
    .we_i          (w_we),
    .row_i         (row_idx),
    .col_i         (col_idx),
    .data_i        (w_q_i),
    .mat_o         (wq_mat)
  );

  proj_unit proj_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .clr_i         (clr),
    .phase_i       (phase),
    .row_idx_i     (row_idx),
    .col_idx_i     (col_idx),
    .x_i           (x_mat),
    .wq_i          (wq_mat),
    .w_k_i         (w_k_i),
    .w_v_i         (w_v_i),
    .q_o           (q_mat),
    .k_o           (k_mat),
    .v_o           (v_mat)
  );

  score_unit score_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .clr_i         (clr),
    .phase_i       (phase),
    .row_idx_i     (row_idx),
    .col_idx_i     (col_idx),
    .q_i           (q_mat),
    .k_i           (k_mat),
    .s_o           (s_mat)
  );

  attn_out out_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .phase_i       (phase),
    .row_idx_i     (row_idx),
    .col_idx_i     (col_idx),
    .s_i           (s_mat),
    .v_i           (v_mat),
    .out_valid_o   (out_valid_o),
    .out_data_o    (out_data_o)
  );

endmodule

/* tb/self_attn_checker.sv */
// concurrent checks on the result port of the attention engine
// bound into self_attn_top by the testbench
`timescale 1ns/1ps

module self_attn_checker (
  input logic           G_clock_K_reg,
  input logic           rst_n,
  input logic           in_valid_i,
  input logic           out_valid_i,
  input attn_pkg::out_t out_data_i
);

  // number of failed properties
  int assert_fails = 0;

  // result bus reads zero between results
  idle_data_zero: assert property (
    @(posedge G_clock_K_reg) disable iff (!rst_n) !out_valid_i |-> out_data_i == '0
  ) else begin
    assert_fails++;
    $error("out_data_o is nonzero while out_valid_o is low");
  end

  // results only come after the load has finished
  no_overlap: assert property (
    @(posedge G_clock_K_reg) disable iff (!rst_n) !(out_valid_i && in_valid_i)
  ) else begin
    assert_fails++;
    $error("out_valid_o is high while in_valid_i is high");
  end

endmodule

/* tb/self_attn_tb.sv */
// testbench for the self-attention engine
// six runs: random T=8, T=4 then T=1, two extreme patterns, T=5
// results are checked in order against a software model of the datapath
`timescale 1ns/1ps

module self_attn_tb;
  import attn_pkg::*;

  // six runs of about 330 cycles, plus reset and margin
  localparam int MAX_CYCLES = 3000;

  typedef data_t mat_t [DIM][DIM];

  logic   G_clock_K_reg;
  logic   rst_n;
  logic   in_valid_i;
  t_t     T_i;
  data_t  in_data_i;
  data_t  w_q_i;
  data_t  w_k_i;
  data_t  w_v_i;
  logic   out_valid_o;
  out_t   out_data_o;

  int     seed = 80453;
  int     errors = 0;
  int     cycles = 0;
  mat_t   x_m;
  mat_t   wq_m;
  mat_t   wk_m;
  mat_t   wv_m;
  // expected results, and per run its name and result count
  longint exp_q [$];
  string  name_q [$];
  int     count_q [$];

  tb_clock_gen clock_gen_i (
    .clk_o   (G_clock_K_reg),
    .rst_n_o (rst_n)
  );

  self_attn_top self_attn_top_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .T_i           (T_i),
    .in_data_i     (in_data_i),
    .w_q_i         (w_q_i),
    .w_k_i         (w_k_i),
    .w_v_i         (w_v_i),
    .out_valid_o   (out_valid_o),
    .out_data_o    (out_data_o)
  );

  bind self_attn_top self_attn_checker checker_i (
    .G_clock_K_reg (G_clock_K_reg),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .out_valid_i   (out_valid_o),
    .out_data_i    (out_data_o)
  );

  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected !== actual) begin
      $display("error: %s expected %0d actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  // bit 0 forced high gives a matrix with no zero entry
  function automatic void fill_random(output mat_t m, input bit nonzero);
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        m[r][c] = data_t'($random(seed));
        if (nonzero) m[r][c][0] = 1'b1;
      end
    end
  endfunction

  function automatic void fill_const(output mat_t m, input data_t v);
    for (int r = 0; r < DIM; r++) begin
      for (int c = 0; c < DIM; c++) begin
        m[r][c] = v;
      end
    end
  endfunction

  // model: Q K V = X W, S = relu(Q K^T) / 3, result = S V
  // queues the row-major results, returns how many there are
  function automatic int compute_expected(input int t_code, input mat_t x, input mat_t wq,
                                          input mat_t wk, input mat_t wv);
    int     rows;
    longint qm [DIM][DIM];
    longint km [DIM][DIM];
    longint vm [DIM][DIM];
    longint sm [DIM][DIM];
    longint acc;
    rows = (t_code == 1) ? 1 : (t_code == 4) ? 4 : DIM;
    for (int i = 0; i < DIM; i++) begin
      for (int c = 0; c < DIM; c++) begin
        qm[i][c] = 0;
        km[i][c] = 0;
        vm[i][c] = 0;
        // masked rows of X count as zero
        if (i < rows) begin
          for (int r = 0; r < DIM; r++) begin
            qm[i][c] += longint'(x[i][r]) * longint'(wq[r][c]);
            km[i][c] += longint'(x[i][r]) * longint'(wk[r][c]);
            vm[i][c] += longint'(x[i][r]) * longint'(wv[r][c]);
          end
        end
      end
    end
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        acc = 0;
        for (int k = 0; k < DIM; k++) acc += qm[i][k] * km[j][k];
        sm[i][j] = (acc < 0) ? 0 : acc / 3;
      end
    end
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < DIM; j++) begin
        acc = 0;
        for (int k = 0; k < DIM; k++) acc += sm[i][k] * vm[k][j];
        exp_q.push_back(acc);
      end
    end
    return rows * DIM;
  endfunction

  // streams X with Wq, then Wk, then Wv, and waits for the result burst to end
  task automatic run_case(input string name, input int t_code);
    int count;
    int r;
    int c;
    count = compute_expected(t_code, x_m, wq_m, wk_m, wv_m);
    name_q.push_back(name);
    count_q.push_back(count);
    for (int blk = 0; blk < 3; blk++) begin
      for (int e = 0; e < LOAD_CYCLES; e++) begin
        @(posedge G_clock_K_reg);
        r = e / DIM;
        c = e % DIM;
        in_valid_i <= 1'b1;
        // T only matters on the first cycle, junk elsewhere
        T_i        <= (blk == 0 && e == 0) ? t_t'(t_code) : t_t'($random(seed));
        in_data_i  <= (blk == 0) ? x_m[r][c] : data_t'($random(seed));
        w_q_i      <= (blk == 0) ? wq_m[r][c] : data_t'($random(seed));
        w_k_i      <= (blk == 1) ? wk_m[r][c] : data_t'($random(seed));
        w_v_i      <= (blk == 2) ? wv_m[r][c] : data_t'($random(seed));
      end
    end
    @(posedge G_clock_K_reg);
    in_valid_i <= 1'b0;
    T_i        <= '0;
    in_data_i  <= '0;
    w_q_i      <= '0;
    w_k_i      <= '0;
    w_v_i      <= '0;
    @(negedge G_clock_K_reg);
    while (!out_valid_o) @(negedge G_clock_K_reg);
    while (out_valid_o) @(negedge G_clock_K_reg);
  endtask

  // results in order, zero data between bursts, burst length per run
  initial begin : compare_outputs
    int     seen;
    logic   prev_valid;
    longint expected;
    string  run_name;
    seen = 0;
    prev_valid = 1'b0;
    forever begin
      @(negedge G_clock_K_reg);
      run_name = (name_q.size() > 0) ? name_q[0] : "no_run";
      if (out_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("an output appeared with no expected result pending");
          errors++;
        end else begin
          expected = exp_q.pop_front();
          check_value($sformatf("%s[%0d]", run_name, seen), expected, out_data_o);
        end
        seen++;
      end else begin
        check_value("idle_zero", 0, out_data_o);
        if (prev_valid) begin
          if (count_q.size() > 0) begin
            check_value({run_name, "_count"}, longint'(count_q.pop_front()), longint'(seen));
            void'(name_q.pop_front());
          end
          seen = 0;
        end
      end
      prev_valid = out_valid_o;
    end
  end

  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge G_clock_K_reg);
      cycles++;
    end
    $display("timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    in_valid_i = 1'b0;
    T_i        = '0;
    in_data_i  = '0;
    w_q_i      = '0;
    w_k_i      = '0;
    w_v_i      = '0;
    wait (rst_n == 1'b1);
    // quiet after reset with no input
    repeat (20) begin
      @(negedge G_clock_K_reg);
      check_value("reset_idle", 0, longint'(out_valid_o));
    end
    fill_random(x_m, 1'b0);
    fill_random(wq_m, 1'b0);
    fill_random(wk_m, 1'b0);
    fill_random(wv_m, 1'b0);
    run_case("rand_t8", 8);
    fill_random(x_m, 1'b0);
    fill_random(wq_m, 1'b0);
    fill_random(wk_m, 1'b0);
    fill_random(wv_m, 1'b0);
    run_case("rand_t4", 4);
    // rows 1 to 7 carry data that must be ignored
    fill_random(x_m, 1'b1);
    fill_random(wq_m, 1'b0);
    fill_random(wk_m, 1'b0);
    fill_random(wv_m, 1'b0);
    run_case("rand_t1_masked", 1);
    // largest magnitudes everywhere
    fill_const(x_m, -8'sd128);
    fill_const(wq_m, -8'sd128);
    fill_const(wk_m, -8'sd128);
    fill_const(wv_m, -8'sd128);
    run_case("extreme_max", 8);
    // Q negative, K positive, every score clamps to zero
    fill_const(x_m, -8'sd128);
    fill_const(wq_m, 8'sd127);
    fill_const(wk_m, -8'sd128);
    fill_const(wv_m, 8'sd127);
    run_case("extreme_relu", 8);
    fill_random(x_m, 1'b0);
    fill_random(wq_m, 1'b0);
    fill_random(wk_m, 1'b0);
    fill_random(wv_m, 1'b0);
    run_case("t5_as_t8", 5);
    repeat (4) @(negedge G_clock_K_reg);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared on the output", exp_q.size());
      errors++;
    end
    $display("closing: %0d errors from checks, %0d from assertions",
             errors, self_attn_top_i.checker_i.assert_fails);
    if (errors == 0 && self_attn_top_i.checker_i.assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb/tb_clock_gen.sv */
// testbench clock and reset source
// 20 ns clock, reset held low for the first 16 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule
